// ==== list.f ====
logic/mtx_pkg.sv
logic/mtx_addr_decode.sv
logic/mtx_data_phase_mux.sv
logic/mtx_default_slave.sv
logic/mtx_decoder.sv
verification/mtx_decoder_assert.sv
verification/tb_mtx_decoder.sv

// ==== logic/mtx_addr_decode.sv ====
`timescale 1ns/1ps

module mtx_addr_decode (
    input  mtx_pkg::addr_phase_t           addr_phase,     // Address phase from input stage
    input  mtx_pkg::port_e                 data_port,      // Current data-phase owner
    input  logic [mtx_pkg::NUM_PORTS-1:0]  stage_active,   // Output stage active flags
    output mtx_pkg::port_e                 addr_port,      // Decoded port for this transfer
    output logic [mtx_pkg::NUM_PORTS-1:0]  port_sel,       // One-hot HSEL to output stages
    output logic                           dflt_sel,       // HSEL to default slave
    output logic                           active          // Active flag of chosen stage
);

    import mtx_pkg::*;

    dec_addr_t            dec_addr;     // HADDR[31:10]
    logic                 idle_trans;   // IDLE in address phase
    logic [NUM_PORTS-1:0] region_hit;   // Address inside region i
    logic [NUM_PORTS-1:0] hold_hit;     // IDLE keeps pointing at port i

    assign dec_addr   = addr_phase.addr;
    assign idle_trans = (addr_phase.trans == TRANS_IDLE);

    // ----------------------------------------------------------
    // Region compare
    // ----------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            region_hit[i] = (dec_addr >= REGION_BASE[i]) && (dec_addr <= REGION_LIMIT[i]);
            // Only one port can equal the data-phase owner
            hold_hit[i]   = idle_trans && (data_port == port_e'(i));
        end
    end

    // ----------------------------------------------------------
    // Port choice
    // ----------------------------------------------------------
    // Lowest region wins, so scan from the top down
    // An IDLE hold on a real port overrides the address
    always_comb
    begin
        addr_port = PORT_DFLT;                      // Unmapped by default
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (region_hit[i])
                addr_port = port_e'(i);
        end
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (hold_hit[i])
                addr_port = port_e'(i);             // Stay on data-phase port
        end
    end

    // ----------------------------------------------------------
    // Select and active
    // ----------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            port_sel[i] = addr_phase.sel && (addr_port == port_e'(i));   // Gated by HSEL
        end
    end

    assign dflt_sel = addr_phase.sel && (addr_port == PORT_DFLT);

    // Default slave is always ready to take a transfer
    always_comb
    begin
        active = 1'b1;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (addr_port == port_e'(i))
                active = stage_active[i];           // Flag of the chosen stage
        end
    end

endmodule

// ==== logic/mtx_data_phase_mux.sv ====
`timescale 1ns/1ps

module mtx_data_phase_mux (
    input  logic                                      HCLK,          // AHB clock
    input  logic                                      HRESETn,       // Sync reset, active low
    input  logic                                      hreadys,       // Input stage HREADY
    input  mtx_pkg::port_e                            addr_port,     // Port of address phase
    input  mtx_pkg::slv_resp_t [mtx_pkg::NUM_PORTS-1:0] port_resp,   // Output stage returns
    input  mtx_pkg::slv_resp_t                        dflt_resp,     // Default slave return
    output mtx_pkg::port_e                            data_port,     // Data-phase owner
    output mtx_pkg::slv_resp_t                        master_resp    // Return to master
);

    import mtx_pkg::*;

    // ----------------------------------------------------------
    // Data-phase port register
    // ----------------------------------------------------------
    // Loads on HREADY of the input stage, not on our own readyout
    // The address phase moves into the data phase only when
    // the whole bus sees the transfer complete
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= PORT_MI0;                  // MI0 owns the bus out of reset
        end
        else if (hreadys)
        begin
            data_port <= addr_port;                 // New data phase begins
        end
    end

    // ----------------------------------------------------------
    // Response mux
    // ----------------------------------------------------------
    // Ready, response and read data travel as one struct
    always_comb
    begin
        master_resp = dflt_resp;                    // Default slave, rdata already zero
        case (data_port)
            PORT_MI0:
            begin
                master_resp = port_resp[0];
            end
            PORT_MI1:
            begin
                master_resp = port_resp[1];
            end
            PORT_MI2:
            begin
                master_resp = port_resp[2];
            end
            PORT_MI3:
            begin
                master_resp = port_resp[3];
            end
            PORT_DFLT:
            begin
                master_resp = dflt_resp;            // Unmapped access owns the phase
            end
        endcase
    end

endmodule

// ==== logic/mtx_decoder.sv ====
`timescale 1ns/1ps

module mtx_decoder (
    input  logic                                        HCLK,          // AHB clock
    input  logic                                        HRESETn,       // Sync reset, active low
    input  logic                                        hreadys,       // Input stage HREADY
    input  mtx_pkg::addr_phase_t                        addr_phase,    // Address phase in
    input  mtx_pkg::slv_resp_t [mtx_pkg::NUM_PORTS-1:0] port_resp,     // Output stage returns
    input  logic [mtx_pkg::NUM_PORTS-1:0]               stage_active,  // Output stage actives
    output logic [mtx_pkg::NUM_PORTS-1:0]               port_sel,      // One-hot port HSEL
    output logic                                        active,        // Chosen stage active
    output mtx_pkg::slv_resp_t                          master_resp    // Return to master
);

    import mtx_pkg::*;

    port_e     addr_port;    // Decoded port, address phase
    port_e     data_port;    // Registered owner, data phase
    logic      dflt_sel;     // Default slave HSEL
    slv_resp_t dflt_resp;    // Default slave return

    // ----------------------------------------------------------
    // Address phase
    // ----------------------------------------------------------
    mtx_addr_decode u_addr_decode (
        .addr_phase   (addr_phase),
        .data_port    (data_port),      // For IDLE hold
        .stage_active (stage_active),
        .addr_port    (addr_port),
        .port_sel     (port_sel),
        .dflt_sel     (dflt_sel),
        .active       (active)
    );

    // ----------------------------------------------------------
    // Data phase
    // ----------------------------------------------------------
    mtx_data_phase_mux u_data_phase_mux (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hreadys     (hreadys),
        .addr_port   (addr_port),
        .port_resp   (port_resp),
        .dflt_resp   (dflt_resp),
        .data_port   (data_port),
        .master_resp (master_resp)
    );

    // Unmapped accesses end up here
    mtx_default_slave u_default_slave (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .dflt_sel  (dflt_sel),
        .hreadys   (hreadys),
        .trans     (addr_phase.trans),
        .dflt_resp (dflt_resp)
    );

endmodule

// ==== logic/mtx_default_slave.sv ====
`timescale 1ns/1ps

module mtx_default_slave (
    input  logic                HCLK,        // AHB clock
    input  logic                HRESETn,     // Sync reset, active low
    input  logic                dflt_sel,    // HSEL from decoder
    input  logic                hreadys,     // Input stage HREADY
    input  mtx_pkg::htrans_e    trans,       // HTRANS of address phase
    output mtx_pkg::slv_resp_t  dflt_resp    // Return to data-phase mux
);

    import mtx_pkg::*;

    typedef enum logic [1:0] {
        DS_IDLE = 2'd0,    // OKAY, zero wait
        DS_ERR1 = 2'd1,    // First ERROR cycle, wait
        DS_ERR2 = 2'd2     // Second ERROR cycle, ready
    } ds_state_e;

    ds_state_e ds_state;
    ds_state_e ds_next;
    logic      err_req;      // Unmapped NONSEQ or SEQ accepted

    assign err_req = dflt_sel && hreadys && ((trans == TRANS_NONSEQ) || (trans == TRANS_SEQ));

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb
    begin
        ds_next = ds_state;
        case (ds_state)
            DS_IDLE: ds_next = err_req ? DS_ERR1 : DS_IDLE;
            DS_ERR1: ds_next = DS_ERR2;                      // Always steps on
            DS_ERR2:
            begin
                // Second cycle ends only when the bus is ready
                if (hreadys)
                    ds_next = err_req ? DS_ERR1 : DS_IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            ds_state <= DS_IDLE;
        else
            ds_state <= ds_next;
    end

    // Two-cycle ERROR, readyout low only in the first
    assign dflt_resp.readyout = (ds_state != DS_ERR1);
    assign dflt_resp.resp     = (ds_state == DS_IDLE) ? RESP_OKAY : RESP_ERROR;
    assign dflt_resp.rdata    = '0;                          // No read data

endmodule

// ==== logic/mtx_pkg.sv ====
package mtx_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------
    localparam int NUM_PORTS    = 4;                   // Real output ports MI0..MI3
    localparam int DATA_W       = 32;                  // Read data width
    localparam int DEC_ADDR_LSB = 10;                  // Lowest decoded address bit
    localparam int DEC_W        = 32 - DEC_ADDR_LSB;   // Decoded field HADDR[31:10]

    typedef logic [DEC_W-1:0] dec_addr_t;

    // Data-phase owner, default slave sits above the real ports
    typedef enum logic [2:0] {
        PORT_MI0  = 3'd0,
        PORT_MI1  = 3'd1,
        PORT_MI2  = 3'd2,
        PORT_MI3  = 3'd3,
        PORT_DFLT = 3'd4
    } port_e;

    // AHB HTRANS encoding
    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'd0,
        TRANS_BUSY   = 2'd1,
        TRANS_NONSEQ = 2'd2,
        TRANS_SEQ    = 2'd3
    } htrans_e;

    // AHB HRESP encoding
    typedef enum logic [1:0] {
        RESP_OKAY  = 2'd0,
        RESP_ERROR = 2'd1,
        RESP_RETRY = 2'd2,
        RESP_SPLIT = 2'd3
    } hresp_e;

    // Address phase from the input stage
    typedef struct packed {
        logic      sel;     // HSEL
        dec_addr_t addr;    // HADDR[31:10]
        htrans_e   trans;   // HTRANS
    } addr_phase_t;

    // Data-phase return of one output stage
    typedef struct packed {
        logic              readyout;   // HREADYOUT
        hresp_e            resp;       // HRESP
        logic [DATA_W-1:0] rdata;      // HRDATA
    } slv_resp_t;

    // ----------------------------------------------------------
    // Region table, inclusive bounds on HADDR[31:10]
    // ----------------------------------------------------------
    localparam dec_addr_t [NUM_PORTS-1:0] REGION_BASE = {
        22'h040000,   // MI3 0x1000_0000
        22'h000080,   // MI2 0x0002_0000
        22'h000040,   // MI1 0x0001_0000
        22'h000000    // MI0 0x0000_0000
    };

    localparam dec_addr_t [NUM_PORTS-1:0] REGION_LIMIT = {
        22'h053FFF,   // MI3 0x14FF_FFFF
        22'h03FFFF,   // MI2 0x0FFF_FFFF
        22'h00007F,   // MI1 0x0001_FFFF
        22'h00003F    // MI0 0x0000_FFFF
    };

endpackage

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_mtx_decoder -o sim_tb \
    && { ./obj_dir/sim_tb > sim.log 2>&1; cat sim.log; } \
    || { echo "Build failed"; exit 1; }
grep -q "^PASS: all tests$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// ==== verification/mtx_decoder_assert.sv ====
`timescale 1ns/1ps

module mtx_decoder_assert (
    input  logic                           HCLK,        // AHB clock
    input  logic                           HRESETn,     // Sync reset, active low
    input  logic                           hreadys,     // Input stage HREADY
    input  logic [mtx_pkg::NUM_PORTS-1:0]  port_sel,    // One-hot port HSEL
    input  mtx_pkg::port_e                 data_port,   // Registered data-phase owner
    input  mtx_pkg::slv_resp_t             dflt_resp    // Default slave return
);

    import mtx_pkg::*;

    // ----------------------------------------------------------
    // Properties
    // ----------------------------------------------------------
    property sel_onehot_p;
        @(posedge HCLK) disable iff (!HRESETn)
        $onehot0(port_sel);                          // Zero or one stage selected
    endproperty

    // Only ERR1 drives readyout low, ERR2 must follow
    property err_second_cycle_p;
        @(posedge HCLK) disable iff (!HRESETn)
        !dflt_resp.readyout |=> (dflt_resp.readyout && (dflt_resp.resp == RESP_ERROR));
    endproperty

    property data_port_hold_p;
        @(posedge HCLK) disable iff (!HRESETn)
        !hreadys |=> $stable(data_port);             // Owner frozen under wait
    endproperty

    assert property (sel_onehot_p)
        else $error("port_sel not one-hot: %b", port_sel);
    assert property (err_second_cycle_p)
        else $error("default slave ERROR cycle missing after wait cycle");
    assert property (data_port_hold_p)
        else $error("data_port changed while hreadys low");

endmodule

// Attach to every decoder instance
bind mtx_decoder mtx_decoder_assert u_decoder_assert (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hreadys   (hreadys),
    .port_sel  (port_sel),
    .data_port (data_port),
    .dflt_resp (dflt_resp)
);

// ==== verification/tb_mtx_decoder.sv ====
`timescale 1ns/1ps

module tb_mtx_decoder;

    import mtx_pkg::*;

    localparam int NUM_CYCLES     = 2000;                // Random stimulus length
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;    // Plus margin for reset
    localparam int RESET_CYCLES   = 3;

    // Region bounds as byte addresses, inclusive
    localparam logic [NUM_PORTS-1:0][31:0] BASE_ADDR  = {32'h1000_0000, 32'h0002_0000,
                                                         32'h0001_0000, 32'h0000_0000};
    localparam logic [NUM_PORTS-1:0][31:0] LIMIT_ADDR = {32'h14FF_FFFF, 32'h0FFF_FFFF,
                                                         32'h0001_FFFF, 32'h0000_FFFF};

    typedef enum int {MS_IDLE, MS_ERR1, MS_ERR2} model_ds_e;   // Model of default slave

    logic                            HCLK;
    logic                            HRESETn;
    logic                            hreadys;
    addr_phase_t                     addr_phase;
    slv_resp_t [NUM_PORTS-1:0]       port_resp;
    logic [NUM_PORTS-1:0]            stage_active;
    logic [NUM_PORTS-1:0]            port_sel;
    logic                            active;
    slv_resp_t                       master_resp;

    port_e     m_port;             // Model data-phase owner
    port_e     m_port_next;
    model_ds_e m_ds;               // Model default slave state
    model_ds_e m_ds_next;
    int        cycle_count = 0;
    int        err1_cycles = 0;    // Coverage of the ERROR sequence
    int        hold_cycles = 0;    // Coverage of IDLE overriding the address

    mtx_decoder DUT (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .hreadys      (hreadys),
        .addr_phase   (addr_phase),
        .port_resp    (port_resp),
        .stage_active (stage_active),
        .port_sel     (port_sel),
        .active       (active),
        .master_resp  (master_resp)
    );

    initial HCLK = 1'b0;
    always #50 HCLK = ~HCLK;       // 100 ns period

    // Hang guard
    always @(posedge HCLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: timeout, run went past %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------------------------
    // Check and reference model
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Region of a decoded field, straight from the address map
    function automatic port_e region_of(input logic [21:0] field);
        logic [31:0] a;
        a = {field, 10'b0};
        for (int r = 0; r < NUM_PORTS; r++)
        begin
            if (a >= BASE_ADDR[r] && a <= LIMIT_ADDR[r])
                return port_e'(r);
        end
        return PORT_DFLT;
    endfunction

    function automatic port_e expect_port(input addr_phase_t ap, input port_e owner);
        if (ap.trans == TRANS_IDLE && owner != PORT_DFLT)
            return owner;                               // IDLE hold on a real port
        return region_of(ap.addr);
    endfunction

    function automatic logic [21:0] pick_field();
        logic [31:0] a;
        int          r;
        case ($urandom % 8)
            0, 1, 2, 3:
            begin
                r = $urandom % NUM_PORTS;               // Edge of a region, off by one
                a = ($urandom % 2) ? LIMIT_ADDR[r] : BASE_ADDR[r];
                return a[31:10] + 22'(($urandom % 3)) - 22'd1;
            end
            4, 5:
            begin
                a = 32'h1500_0000 + ($urandom % 32'hEB00_0000);   // Unmapped space
                return a[31:10];
            end
            default: return 22'($urandom);
        endcase
    endfunction

    task automatic drive_random_inputs();
        addr_phase_t               ap;
        slv_resp_t [NUM_PORTS-1:0] pr;
        ap.sel   = (($urandom % 10) < 8);
        ap.addr  = pick_field();
        ap.trans = htrans_e'($urandom % 4);
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            pr[i].readyout = 1'($urandom % 2);
            pr[i].resp     = hresp_e'($urandom % 4);
            pr[i].rdata    = $urandom;
        end
        addr_phase   <= ap;
        port_resp    <= pr;
        stage_active <= 4'($urandom);
        hreadys      <= (($urandom % 10) < 7);
    endtask

    task automatic check_outputs();
        port_e                p;
        logic [NUM_PORTS-1:0] one;
        logic [NUM_PORTS-1:0] exp_sel;
        slv_resp_t            exp_resp;
        one = 1;
        p   = expect_port(addr_phase, m_port);
        exp_sel = (addr_phase.sel && p != PORT_DFLT) ? (one << p) : '0;
        check_value("port_sel", port_sel, exp_sel);
        check_value("active", active, (p == PORT_DFLT) ? 1'b1 : stage_active[p]);
        if (m_port == PORT_DFLT)
        begin
            // Default slave has no data
            case (m_ds)
                MS_ERR1: exp_resp = '{readyout: 1'b0, resp: RESP_ERROR, rdata: '0};
                MS_ERR2: exp_resp = '{readyout: 1'b1, resp: RESP_ERROR, rdata: '0};
                default: exp_resp = '{readyout: 1'b1, resp: RESP_OKAY, rdata: '0};
            endcase
        end
        else
            exp_resp = port_resp[m_port];
        check_value("master_resp", master_resp, exp_resp);
        if (m_ds == MS_ERR1)
            err1_cycles++;
        if (addr_phase.trans == TRANS_IDLE && p != region_of(addr_phase.addr))
            hold_cycles++;
    endtask

    // Next state of the model from this cycle's inputs
    task automatic model_step();
        port_e p;
        logic  err;
        p   = expect_port(addr_phase, m_port);
        err = addr_phase.sel && (p == PORT_DFLT) && hreadys &&
              (addr_phase.trans == TRANS_NONSEQ || addr_phase.trans == TRANS_SEQ);
        m_port_next = hreadys ? p : m_port;
        case (m_ds)
            MS_IDLE: m_ds_next = err ? MS_ERR1 : MS_IDLE;
            MS_ERR1: m_ds_next = MS_ERR2;
            default: m_ds_next = hreadys ? (err ? MS_ERR1 : MS_IDLE) : MS_ERR2;
        endcase
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial
    begin
        int seed_ret;
        seed_ret     = $urandom(32'h3a968578);
        HRESETn      <= 1'b0;
        hreadys      <= 1'b0;                           // Holds reset state past release
        addr_phase   <= '0;
        port_resp    <= '0;
        stage_active <= '0;
        m_port_next  = PORT_MI0;
        m_ds_next    = MS_IDLE;
        repeat (RESET_CYCLES) @(posedge HCLK);
        HRESETn <= 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++)
        begin
            @(posedge HCLK);
            m_port = m_port_next;                       // Model follows the clock edge
            m_ds   = m_ds_next;
            drive_random_inputs();
            @(negedge HCLK);                            // Outputs settled here
            check_outputs();
            model_step();
        end
        if (err1_cycles == 0 || hold_cycles == 0)
        begin
            $display("ERROR: stimulus never reached the ERROR sequence or an IDLE hold");
            $display("FAIL: see errors above");
            $fatal(1, "coverage");
        end
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
